// File: verilog/noc_macros.svh
/* NoC router input port constants
   VC count, flit width, VC buffer depth and downstream credit depth */
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// Number of virtual channels
`define NOC_NUM_VC   2
// Bits of a VC number, one bit covers 2 VCs
`define NOC_VC_W     1
// Flit payload width
`define NOC_DATA_W   32
// Slots per VC buffer
`define NOC_VC_DEPTH 4
// Downstream slots per VC, reset value of each credit counter
`define NOC_CREDITS  4

`endif

// File: verilog/noc_pkg.sv
/* NoC router input port package
   Flit type, arbiter state and flit struct shared by the design */
`include "noc_macros.svh"

package noc_pkg;

  // VC number carried beside each flit
  typedef logic [`NOC_VC_W-1:0] vc_id_t;

  // Flit position inside a packet
  typedef enum logic [1:0] {
    FLIT_HEAD      = 2'd0,
    FLIT_BODY      = 2'd1,
    FLIT_TAIL      = 2'd2,
    FLIT_HEAD_TAIL = 2'd3
  } flit_type_e;

  // Wormhole lock of the output arbiter
  typedef enum logic {
    ARB_IDLE   = 1'b0,
    ARB_LOCKED = 1'b1
  } arb_state_e;

  // Flit as stored in the VC buffers
  typedef struct packed {
    flit_type_e              ftype;
    logic [`NOC_DATA_W-1:0]  data;
  } flit_t;

endpackage

// File: verilog/flit_if.sv
/* Flit link interface
   One valid/ready channel carrying a VC number and a flit */
`timescale 1ns/10ps

interface flit_if;
  import noc_pkg::*;

  // Transfer on a rising edge with valid and ready both high
  logic    valid;
  logic    ready;
  // Held stable by the sender while stalled
  vc_id_t  vc;
  flit_t   flit;

  // Sending side
  modport tx (
    output valid,
    output vc,
    output flit,
    input  ready
  );

  // Receiving side
  modport rx (
    input  valid,
    input  vc,
    input  flit,
    output ready
  );

endinterface

// File: verilog/vc_fifo.sv
/* VC flit buffer
   Circular buffer of flits for one virtual channel, with full and empty flags */
`timescale 1ns/10ps
`include "noc_macros.svh"

module vc_fifo (
  input  logic            clk,
  input  logic            arst_n_i,
  flit_if.rx              wr_i,
  output logic            rd_valid_o,
  output noc_pkg::flit_t  rd_flit_o,
  input  logic            pop_i,
  output logic            full_o,
  output logic            empty_o
);
  import noc_pkg::*;

  localparam int DEPTH = `NOC_VC_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Flit storage
  flit_t             mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;

  // Accept while a slot is free
  assign wr_i.ready = ~full_o;
  assign push       = wr_i.valid & wr_i.ready;
  // Pop ignored when nothing is stored
  assign pop        = pop_i & ~empty_o;

  assign full_o     = (count == CNT_W'(DEPTH));
  assign empty_o    = (count == '0);
  // Head slot goes straight to the arbiter
  assign rd_valid_o = ~empty_o;
  assign rd_flit_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_i.flit;
    end
  end

  // Pointers wrap at DEPTH
  // Occupancy follows both pointers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Arbiter only pops a VC whose head is valid
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n_i)
    pop_i |-> !empty_o);

  a_count_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
    count <= CNT_W'(DEPTH));

endmodule

// File: verilog/vc_credit_counter.sv
/* VC credit counter
   Free slot count of one VC in the downstream router */
`timescale 1ns/10ps
`include "noc_macros.svh"

module vc_credit_counter (
  input  logic  clk,
  input  logic  arst_n_i,
  input  logic  consume_i,
  input  logic  credit_i,
  output logic  has_credit_o
);

  localparam int CREDITS = `NOC_CREDITS;
  localparam int CNT_W   = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] count;

  // Starts full, one slot per downstream buffer entry
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count <= CNT_W'(CREDITS);
    end else begin
      // Send and return in one cycle leave the count alone
      case ({consume_i, credit_i})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign has_credit_o = (count != '0);

  // Downstream never returns more than it received
  a_count_max: assert property (@(posedge clk) disable iff (!arst_n_i)
    count <= CNT_W'(CREDITS));

  // Arbiter must skip a VC at zero credit
  a_no_send_at_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
    consume_i |-> count != '0);

endmodule

// File: verilog/vc_output_arbiter.sv
/* VC output arbiter
   Lowest-index priority over the VC buffers with a wormhole lock FSM */
`timescale 1ns/10ps
`include "noc_macros.svh"

module vc_output_arbiter (
  input  logic                               clk,
  input  logic                               arst_n_i,
  input  logic           [`NOC_NUM_VC-1:0]   vc_valid_i,
  input  noc_pkg::flit_t [`NOC_NUM_VC-1:0]   vc_flit_i,
  input  logic           [`NOC_NUM_VC-1:0]   has_credit_i,
  output logic           [`NOC_NUM_VC-1:0]   pop_o,
  flit_if.tx                                 out_o
);
  import noc_pkg::*;

  localparam int NUM_VC = `NOC_NUM_VC;

  arb_state_e         state;
  vc_id_t             lock_vc;
  vc_id_t             sel_vc;
  logic               sel_ok;
  logic               xfer;
  logic [NUM_VC-1:0]  eligible;

  // Candidate needs a head flit and a downstream slot
  assign eligible = vc_valid_i & has_credit_i;

  always_comb begin
    sel_vc = lock_vc;
    sel_ok = 1'b0;
    if (state == ARB_IDLE) begin
      // Downward scan, so the lowest index wins
      for (int i = NUM_VC - 1; i >= 0; i--) begin
        if (eligible[i]) begin
          sel_vc = vc_id_t'(i);
          sel_ok = 1'b1;
        end
      end
    end else begin
      // Locked VC only, stalls while out of credit
      sel_ok = eligible[lock_vc];
    end
  end

  assign out_o.valid = sel_ok;
  assign out_o.vc    = sel_vc;
  assign out_o.flit  = vc_flit_i[sel_vc];
  assign xfer        = sel_ok & out_o.ready;

  // One pop strobe per completed transfer
  always_comb begin
    pop_o = '0;
    if (xfer) begin
      pop_o[sel_vc] = 1'b1;
    end
  end

  // Lock FSM
  // A stalled offer also locks, so a lower VC cannot take the link mid-handshake
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state   <= ARB_IDLE;
      lock_vc <= '0;
    end else if (xfer) begin
      lock_vc <= sel_vc;
      case (out_o.flit.ftype)
        FLIT_HEAD:      state <= ARB_LOCKED;
        FLIT_TAIL:      state <= ARB_IDLE;
        FLIT_HEAD_TAIL: state <= ARB_IDLE;
        default:        state <= state;
      endcase
    end else if (sel_ok) begin
      state   <= ARB_LOCKED;
      lock_vc <= sel_vc;
    end
  end

  // Offered flit holds until the sink takes it
  a_out_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    out_o.valid && !out_o.ready |=>
      out_o.valid && $stable(out_o.vc) && $stable(out_o.flit));

endmodule

// File: verilog/input_datapath.sv
/* Router input datapath
   Demux into per-VC buffers, credit tracking and the output arbiter */
`timescale 1ns/10ps
`include "noc_macros.svh"

module input_datapath (
  input  logic                     clk,
  input  logic                     arst_n_i,
  flit_if.rx                       fin,
  flit_if.tx                       fout,
  input  logic [`NOC_NUM_VC-1:0]   credit_i,
  output logic [`NOC_NUM_VC-1:0]   full_o,
  output logic [`NOC_NUM_VC-1:0]   empty_o
);
  import noc_pkg::*;

  localparam int NUM_VC = `NOC_NUM_VC;

  // Per-VC write ready, head, credit and pop
  logic  [NUM_VC-1:0]  fifo_ready;
  logic  [NUM_VC-1:0]  head_valid;
  flit_t [NUM_VC-1:0]  head_flit;
  logic  [NUM_VC-1:0]  has_credit;
  logic  [NUM_VC-1:0]  pop;

  for (genvar g = 0; g < NUM_VC; g++) begin : gen_vc
    // Write link into this VC's buffer
    flit_if u_wr ();

    // Demux, valid only toward the addressed VC
    assign u_wr.valid     = fin.valid & (fin.vc == vc_id_t'(g));
    assign u_wr.vc        = fin.vc;
    assign u_wr.flit      = fin.flit;
    assign fifo_ready[g]  = u_wr.ready;

    vc_fifo u_fifo (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .wr_i       (u_wr.rx),
      .rd_valid_o (head_valid[g]),
      .rd_flit_o  (head_flit[g]),
      .pop_i      (pop[g]),
      .full_o     (full_o[g]),
      .empty_o    (empty_o[g])
    );

    vc_credit_counter u_credit (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .consume_i    (pop[g]),
      .credit_i     (credit_i[g]),
      .has_credit_o (has_credit[g])
    );
  end

  // Input stalls only when the addressed VC is full
  assign fin.ready = fifo_ready[fin.vc];

  vc_output_arbiter u_arbiter (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .vc_valid_i   (head_valid),
    .vc_flit_i    (head_flit),
    .has_credit_i (has_credit),
    .pop_o        (pop),
    .out_o        (fout)
  );

endmodule

// File: verilog/router_input_port.sv
/* Router input port top level
   Plain link ports mapped onto the internal flit links of the datapath */
`timescale 1ns/10ps
`include "noc_macros.svh"

module router_input_port (
  input  logic                     clk,
  input  logic                     arst_n_i,
  // Upstream link
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  noc_pkg::vc_id_t          in_vc_i,
  input  noc_pkg::flit_type_e      in_type_i,
  input  logic [`NOC_DATA_W-1:0]   in_data_i,
  // Downstream link
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output noc_pkg::vc_id_t          out_vc_o,
  output noc_pkg::flit_type_e      out_type_o,
  output logic [`NOC_DATA_W-1:0]   out_data_o,
  // Credit returns, one pulse per freed downstream slot
  input  logic [`NOC_NUM_VC-1:0]   credit_i,
  // Buffer status per VC
  output logic [`NOC_NUM_VC-1:0]   full_o,
  output logic [`NOC_NUM_VC-1:0]   empty_o
);

  flit_if u_fin ();
  flit_if u_fout ();

  // Pack inputs into the flit struct
  assign u_fin.valid      = in_valid_i;
  assign u_fin.vc         = in_vc_i;
  assign u_fin.flit.ftype = in_type_i;
  assign u_fin.flit.data  = in_data_i;
  assign in_ready_o       = u_fin.ready;

  // Unpack the outbound flit
  assign out_valid_o      = u_fout.valid;
  assign out_vc_o         = u_fout.vc;
  assign out_type_o       = u_fout.flit.ftype;
  assign out_data_o       = u_fout.flit.data;
  assign u_fout.ready     = out_ready_i;

  input_datapath u_datapath (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .fin      (u_fin.rx),
    .fout     (u_fout.tx),
    .credit_i (credit_i),
    .full_o   (full_o),
    .empty_o  (empty_o)
  );

endmodule

// File: tb/tb_checks.svh
/* Router input port reference model and typed compare tasks */

// Oldest flit accepted on a VC and not yet seen at the output
function automatic flit_t pop_expected(input vc_id_t vc);
  flit_t f;
  f = ref_q[vc].pop_front();
  return f;
endfunction

// Flit type at position idx of a packet of len flits
function automatic flit_type_e packet_type(input int idx, input int len);
  if (len == 1) return FLIT_HEAD_TAIL;
  if (idx == 0) return FLIT_HEAD;
  if (idx == len - 1) return FLIT_TAIL;
  return FLIT_BODY;
endfunction

task automatic check_flit(input string name, input flit_t got, input flit_t exp);
  checks++;
  if (got !== exp) begin
    value_errs++;
    $display("FAILED %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

task automatic check_vc(input string name, input vc_id_t got, input vc_id_t exp);
  checks++;
  if (got !== exp) begin
    value_errs++;
    $display("FAILED %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

// Per-VC status vectors, full or empty
task automatic check_flags(input string name, input logic [NUM_VC-1:0] got,
                           input logic [NUM_VC-1:0] exp);
  checks++;
  if (got !== exp) begin
    value_errs++;
    $display("FAILED %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

// Handshake bits, valid or ready
task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    value_errs++;
    $display("FAILED %s at %0t: got %h expected %h", name, $time, got, exp);
  end
endtask

// File: tb/tb_router_input_port.sv
/* Router input port testbench
   Directed back-pressure and credit phases, then random packets on both VCs */
`timescale 1ns/10ps
`include "noc_macros.svh"

module tb_router_input_port;
  import noc_pkg::*;

  localparam int NUM_VC      = `NOC_NUM_VC;
  localparam int NUM_PKTS    = 40;
  // Directed phases send 7 flits
  localparam int FIXED_FLITS = 7;

  logic                    clk;
  logic                    arst_n_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  vc_id_t                  in_vc_i;
  flit_type_e              in_type_i;
  logic [`NOC_DATA_W-1:0]  in_data_i;
  logic                    out_valid_o;
  logic                    out_ready_i;
  vc_id_t                  out_vc_o;
  flit_type_e              out_type_o;
  logic [`NOC_DATA_W-1:0]  out_data_o;
  logic [NUM_VC-1:0]       credit_i;
  logic [NUM_VC-1:0]       full_o;
  logic [NUM_VC-1:0]       empty_o;

  integer             seed;
  int                 cycles;
  int                 cycle_limit;
  int                 checks;
  int                 value_errs;
  int                 rule_errs;
  int                 pending;
  // Reference queues and downstream credit mirror, per VC
  flit_t              ref_q [NUM_VC][$];
  int                 credit_m [NUM_VC];
  int                 sent [NUM_VC];
  int                 returned [NUM_VC];
  // Expected lock of the output link
  logic               lock_m;
  vc_id_t             lock_vc_m;
  logic               in_fire;
  logic               rdy_random;
  logic               credit_en;
  vc_id_t             pkt_vc [NUM_PKTS];
  int                 pkt_len [NUM_PKTS];
  logic [NUM_VC-1:0]  elig;
  logic [NUM_VC-1:0]  exp_full;
  logic [NUM_VC-1:0]  exp_empty;
  logic               exp_valid;
  vc_id_t             exp_vc;
  flit_t              got_flit;

  `include "tb_checks.svh"

  router_input_port i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Offer one flit from a rising edge, return on the edge that takes it
  task automatic send_flit(input vc_id_t vc, input flit_type_e ftype);
    in_valid_i <= 1'b1;
    in_vc_i    <= vc;
    in_type_i  <= ftype;
    in_data_i  <= $random(seed);
    @(posedge clk);
    while (!in_fire) begin
      @(posedge clk);
    end
  endtask

  // Random sink ready and credit returns, never more than consumed
  always @(posedge clk) begin
    if (rdy_random) begin
      out_ready_i <= ($random(seed) & 1) != 0;
    end
    for (int v = 0; v < NUM_VC; v++) begin
      credit_i[v] <= credit_en && (sent[v] > returned[v]) && (($random(seed) & 1) != 0);
    end
  end

  // Compare process, sampled mid-cycle while everything is stable
  always @(negedge clk) begin
    if (arst_n_i) begin
      for (int v = 0; v < NUM_VC; v++) begin
        elig[v]      = (ref_q[v].size() > 0) && (credit_m[v] > 0);
        exp_full[v]  = ref_q[v].size() == `NOC_VC_DEPTH;
        exp_empty[v] = ref_q[v].size() == 0;
      end
      // Locked link only looks at its VC, idle link picks the lowest
      exp_valid = lock_m ? elig[lock_vc_m] : |elig;
      exp_vc    = lock_vc_m;
      if (!lock_m) begin
        for (int v = NUM_VC - 1; v >= 0; v--) begin
          if (elig[v]) exp_vc = vc_id_t'(v);
        end
      end
      check_bit("out_valid_o", out_valid_o, exp_valid);
      if (out_valid_o && exp_valid) check_vc("out_vc_o", out_vc_o, exp_vc);
      check_bit("in_ready_o", in_ready_o, ref_q[in_vc_i].size() < `NOC_VC_DEPTH);
      check_flags("full_o", full_o, exp_full);
      check_flags("empty_o", empty_o, exp_empty);
      if (out_valid_o && out_ready_i) begin
        got_flit.ftype = out_type_o;
        got_flit.data  = out_data_o;
        if (ref_q[out_vc_o].size() == 0) begin
          rule_errs++;
          $display("ERROR at %0t: flit left VC %0d with nothing pending", $time, out_vc_o);
        end else begin
          check_flit("out_flit", got_flit, pop_expected(out_vc_o));
        end
        if (credit_m[out_vc_o] == 0) begin
          rule_errs++;
          $display("ERROR at %0t: flit left VC %0d without a credit", $time, out_vc_o);
        end
        credit_m[out_vc_o]--;
        sent[out_vc_o]++;
        // Head opens the wormhole, tail or single flit closes it
        if (out_type_o == FLIT_HEAD) begin
          lock_m    = 1'b1;
          lock_vc_m = out_vc_o;
        end else if (out_type_o != FLIT_BODY) begin
          lock_m = 1'b0;
        end
      end else if (out_valid_o) begin
        // Stalled offer keeps the link
        lock_m    = 1'b1;
        lock_vc_m = out_vc_o;
      end
      for (int v = 0; v < NUM_VC; v++) begin
        if (credit_i[v]) begin
          credit_m[v]++;
          returned[v]++;
        end
      end
      in_fire = in_valid_i && in_ready_o;
      if (in_fire) ref_q[in_vc_i].push_back({in_type_i, in_data_i});
      pending = 0;
      for (int v = 0; v < NUM_VC; v++) pending += ref_q[v].size();
    end
  end

  initial begin
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    in_vc_i     = '0;
    in_type_i   = FLIT_HEAD_TAIL;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    credit_i    = '0;
    rdy_random  = 1'b0;
    credit_en   = 1'b0;
    lock_m      = 1'b0;
    lock_vc_m   = '0;
    in_fire     = 1'b0;
    checks      = 0;
    value_errs  = 0;
    rule_errs   = 0;
    pending     = 0;
    seed        = 40710;
    for (int v = 0; v < NUM_VC; v++) begin
      credit_m[v] = `NOC_CREDITS;
      sent[v]     = 0;
      returned[v] = 0;
    end
    cycle_limit = FIXED_FLITS;
    for (int p = 0; p < NUM_PKTS; p++) begin
      pkt_vc[p]   = vc_id_t'($random(seed));
      pkt_len[p]  = 1 + ($random(seed) & 3);
      cycle_limit += pkt_len[p];
    end
    cycle_limit = 40 * cycle_limit + 100;
    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;
    @(posedge clk);

    // Fill VC0 with the sink stalled, empty flags checked each cycle
    for (int i = 0; i < `NOC_VC_DEPTH; i++) begin
      send_flit('0, FLIT_HEAD_TAIL);
    end
    in_valid_i <= 1'b1;
    in_vc_i    <= '0;
    @(negedge clk);
    check_bit("in_ready_o", in_ready_o, 1'b0);
    check_flags("full_o", full_o, NUM_VC'(1));
    @(posedge clk);
    in_valid_i <= 1'b0;
    @(posedge clk);
    send_flit(vc_id_t'(1), FLIT_HEAD_TAIL);

    // No credit returns, VC0 stops after its credits run out
    out_ready_i <= 1'b1;
    send_flit('0, FLIT_HEAD_TAIL);
    send_flit('0, FLIT_HEAD_TAIL);
    in_valid_i <= 1'b0;
    while (sent[0] < `NOC_CREDITS || sent[1] < 1) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_flags("empty_o", empty_o, NUM_VC'(2));
    @(posedge clk);

    // Random packets with random sink ready and credit returns
    rdy_random = 1'b1;
    credit_en  = 1'b1;
    for (int p = 0; p < NUM_PKTS; p++) begin
      for (int i = 0; i < pkt_len[p]; i++) begin
        if (($random(seed) & 3) == 0) begin
          in_valid_i <= 1'b0;
          @(posedge clk);
        end
        send_flit(pkt_vc[p], packet_type(i, pkt_len[p]));
      end
    end
    in_valid_i  <= 1'b0;
    rdy_random   = 1'b0;
    out_ready_i <= 1'b1;
    while (pending != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("checks %0d, value errors %0d, rule errors %0d", checks, value_errs, rule_errs);
    if (value_errs == 0 && rule_errs == 0 && checks > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin
    cycles = 0;
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: output stalled, run did not finish within %0d cycles", cycle_limit);
    $display("checks %0d, value errors %0d, rule errors %0d", checks, value_errs, rule_errs);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: files.f
+incdir+verilog
+incdir+tb
verilog/noc_pkg.sv
verilog/flit_if.sv
verilog/vc_fifo.sv
verilog/vc_credit_counter.sv
verilog/vc_output_arbiter.sv
verilog/input_datapath.sv
verilog/router_input_port.sv
tb/tb_router_input_port.sv

// File: Makefile
# Verilator simulation of the router input port testbench

VERILATOR ?= verilator
TOP       ?= tb_router_input_port
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
